/* project.f */
logic/lsq_cfg_pkg.sv
logic/lsq_types_pkg.sv
logic/store_forward.sv
logic/store_queue.sv
logic/load_queue.sv
logic/lsq_top.sv
tb/tb_clock.sv
tb/lsq_chk.sv
tb/lsq_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module lsq_tb -f project.f -o lsq_sim
./obj_dir/lsq_sim > sim.log 2>&1
cat sim.log
if grep -q "TB FAILED" sim.log; then
  exit 1
fi

/* tb/lsq_tb.sv */
`timescale 1ns/1ns

module lsq_tb;

  import lsq_cfg_pkg::*;
  import lsq_types_pkg::*;

  typedef logic [addr_w-1:0] addr_t;

  // Tests run well under 100 cycles
  localparam int max_cycles = 400;

  logic          clock, reset, store_ack, dispatch_ready, load_accept;
  dispatch_req_t dispatch;
  store_exec_t   store_exec;
  load_exec_t    load_exec;
  retire_req_t   retire;
  cache_rsp_t    load_rsp;
  lsq_idx_t      dispatch_idx;
  cache_write_t  store_write;
  cache_read_t   load_read;
  load_result_t  load_result;

  // Reference model, stores kept oldest first
  sq_entry_t         stores[$];
  int                load_bound[64];
  int                n_stores = 0;
  int                committed = 0;
  int                n_loads = 0;
  int                retired = 0;
  int                errors = 0;
  int                cycles = 0;
  int                seed = 93200;
  logic              rsp_enable = 1'b1;
  logic [data_w-1:0] mem[addr_t];

  tb_clock clk0 (.clock(clock), .reset(reset));

  lsq_top dut0 (.*);

  // Cache model takes acknowledged writes
  always @(posedge clock) begin
    if (!reset && store_write.wr_en && store_ack) begin
      mem[store_write.addr] = store_write.data;
    end
  end

  always @(posedge clock) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("Run timed out after %0d cycles", cycles);
      $display("TB FAILED");
      $finish;
    end
  end

  function automatic logic [data_w-1:0] cache_word(addr_t a);
    if (mem.exists(a)) begin
      return mem[a];
    end
    // Unwritten lines hold a pattern of the whole address
    return {a, 3'b011} ^ 64'h5a5a_c3c3_0f0f_9696;
  endfunction

  // Reads answered in the same cycle
  assign load_rsp = '{valid: load_read.rd_en && rsp_enable, data: cache_word(load_read.addr)};

  task automatic clear_inputs();
    dispatch   = '0;
    store_exec = '0;
    load_exec  = '0;
    retire     = '0;
    store_ack  = 1'b0;
  endtask

  task automatic next_cycle();
    @(negedge clock);
    clear_inputs();
  endtask

  task automatic check_dispatch(logic ready, lsq_idx_t idx, logic exp_ready, lsq_idx_t exp_idx);
    if (ready !== exp_ready || idx !== exp_idx) begin
      errors++;
      $display("FAIL %0t: dispatch ready %b idx %0d, expected ready %b idx %0d", $time, ready,
               idx, exp_ready, exp_idx);
    end
  endtask

  task automatic check_write(cache_write_t got, cache_write_t exp, string what);
    if (got.wr_en !== exp.wr_en || (exp.wr_en && got !== exp)) begin
      errors++;
      $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_read(cache_read_t got, logic accept, cache_read_t exp, logic exp_accept);
    if (got !== exp || accept !== exp_accept) begin
      errors++;
      $display("FAIL %0t: load issue rd_en %b accept %b, expected rd_en %b accept %b", $time,
               got.rd_en, accept, exp.rd_en, exp_accept);
    end
  endtask

  task automatic check_result(load_result_t got, load_result_t exp);
    if (got.done !== exp.done || (exp.done && got !== exp)) begin
      errors++;
      $display("FAIL %0t: load result got %h expected %h", $time, got, exp);
    end
  endtask

  // At most seven entries in use per queue
  task automatic dispatch_op(logic is_store);
    int   used;
    logic exp_ready;
    next_cycle();
    dispatch.valid    = 1'b1;
    dispatch.is_store = is_store;
    used      = is_store ? n_stores - committed : n_loads - retired;
    exp_ready = used < lsq_depth - 1;
    #1;
    check_dispatch(dispatch_ready, dispatch_idx, exp_ready,
                   lsq_idx_t'(is_store ? n_stores : n_loads));
    if (exp_ready && is_store) begin
      stores.push_back('0);
      n_stores++;
    end else if (exp_ready) begin
      load_bound[n_loads] = n_stores;
      n_loads++;
    end
  endtask

  task automatic exec_store(int seq, addr_t a, logic [data_w-1:0] d);
    next_cycle();
    store_exec.valid  = 1'b1;
    store_exec.sq_idx = lsq_idx_t'(seq);
    store_exec.addr   = a;
    store_exec.data   = d;
    stores[seq - committed] = '{valid: 1'b1, addr: a, data: d};
  endtask

  // Youngest older store with the same address wins, else the cache answers
  task automatic exec_load(int lseq, addr_t a);
    load_result_t exp;
    cache_read_t  exp_rd;
    next_cycle();
    exp = '{done: 1'b0, lq_idx: lsq_idx_t'(lseq), forwarded: 1'b0, data: cache_word(a)};
    for (int s = committed; s < load_bound[lseq]; s++) begin
      if (stores[s - committed].valid && stores[s - committed].addr == a) begin
        exp.forwarded = 1'b1;
        exp.data      = stores[s - committed].data;
      end
    end
    exp.done  = exp.forwarded || rsp_enable;
    exp_rd    = '{rd_en: !exp.forwarded, addr: a};
    load_exec = '{valid: 1'b1, lq_idx: exp.lq_idx, addr: a};
    #1;
    check_read(load_read, load_accept, exp_rd, exp.done);
    next_cycle();
    #1;
    check_result(load_result, exp);
  endtask

  task automatic retire_loads();
    while (retired < n_loads) begin
      next_cycle();
      retire.load = 1'b1;
      retired++;
    end
  endtask

  task automatic test_alloc_full();
    for (int i = 0; i < lsq_depth; i++) begin
      dispatch_op(1'b1);
    end
    // Loads still go in while the store queue is full
    for (int i = 0; i < lsq_depth; i++) begin
      dispatch_op(1'b0);
    end
    retire_loads();
  endtask

  task automatic test_commit();
    cache_write_t exp;
    int           hold;
    for (int s = 0; s < n_stores; s++) begin
      exec_store(s, addr_t'(16 + s), {$random(seed), $random(seed)});
    end
    while (stores.size() > 0) begin
      // Ack held back zero to three cycles
      hold = $random(seed) & 3;
      for (int c = 0; c <= hold; c++) begin
        next_cycle();
        retire.store = 1'b1;
        store_ack    = c == hold;
        exp          = '{wr_en: 1'b1, addr: stores[0].addr, data: stores[0].data};
        #1;
        check_write(store_write, exp, "store commit");
      end
      stores.delete(0);
      committed++;
    end
    next_cycle();
    retire.store = 1'b1;
    store_ack    = 1'b1;
    #1;
    check_write(store_write, '0, "empty store queue");
  endtask

  task automatic test_forward();
    int s;
    int l;
    s = n_stores;
    l = n_loads;
    repeat (3) dispatch_op(1'b1);
    dispatch_op(1'b0);
    exec_store(s, addr_t'('h20), {$random(seed), $random(seed)});
    exec_store(s + 1, addr_t'('h21), {$random(seed), $random(seed)});
    exec_store(s + 2, addr_t'('h20), {$random(seed), $random(seed)});
    exec_load(l, addr_t'('h20));
  endtask

  task automatic test_younger();
    int l;
    l = n_loads;
    dispatch_op(1'b0);
    dispatch_op(1'b1);
    exec_store(n_stores - 1, addr_t'('h30), {$random(seed), $random(seed)});
    exec_load(l, addr_t'('h30));
  endtask

  task automatic test_retry();
    int l;
    l = n_loads;
    dispatch_op(1'b0);
    rsp_enable = 1'b0;
    exec_load(l, addr_t'('h40));
    rsp_enable = 1'b1;
    exec_load(l, addr_t'('h40));
    retire_loads();
    dispatch_op(1'b0);
  endtask

  initial begin
    clear_inputs();
    @(negedge reset);
    test_alloc_full();
    test_commit();
    test_forward();
    test_younger();
    test_retry();
    next_cycle();
    $display("Run finished with %0d errors", errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* tb/lsq_chk.sv */
`timescale 1ns/1ns

module lsq_chk (
  input logic                    clock,
  input logic                    reset,
  input logic                    take,
  input logic                    full,
  input logic                    wr_en,
  input logic                    head_valid,
  input lsq_types_pkg::lsq_idx_t head,
  input logic                    advance
);

  no_take_when_full: assert property (@(posedge clock) disable iff (reset) take |-> !full)
    else $error("Dispatch accepted while the queue is full");

  write_needs_valid: assert property (@(posedge clock) disable iff (reset) wr_en |-> head_valid)
    else $error("Head entry used while its queue holds no entry");

  // Head only moves after the ack or retire of the cycle before
  head_moves_on_advance: assert property (@(posedge clock) disable iff (reset)
    !$stable(head) |-> $past(advance))
    else $error("Queue head moved without an advance");

endmodule

bind store_queue lsq_chk chk0 (
  .clock      (clock),
  .reset      (reset),
  .take       (store_alloc),
  .full       (full),
  .wr_en      (store_write.wr_en),
  .head_valid (head != tail),
  .head       (head),
  .advance    (store_ack)
);

bind load_queue lsq_chk chk1 (
  .clock      (clock),
  .reset      (reset),
  .take       (load_alloc),
  .full       (full),
  .wr_en      (retire_load),
  .head_valid (head != tail),
  .head       (head),
  .advance    (retire_load)
);

/* tb/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  // Two rising edges under reset, released on a falling edge
  initial begin
    reset = 1'b1;
    repeat (2) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
  end

endmodule

/* logic/lsq_top.sv */
`timescale 1ns/1ns

module lsq_top (
  input  logic                         clock,
  input  logic                         reset,
  input  lsq_types_pkg::dispatch_req_t dispatch,
  input  lsq_types_pkg::store_exec_t   store_exec,
  input  lsq_types_pkg::load_exec_t    load_exec,
  input  lsq_types_pkg::retire_req_t   retire,
  input  lsq_types_pkg::cache_rsp_t    load_rsp,
  input  logic                         store_ack,
  output logic                         dispatch_ready,
  output lsq_types_pkg::lsq_idx_t      dispatch_idx,
  output logic                         load_accept,
  output lsq_types_pkg::cache_write_t  store_write,
  output lsq_types_pkg::cache_read_t   load_read,
  output lsq_types_pkg::load_result_t  load_result
);

  import lsq_cfg_pkg::*;
  import lsq_types_pkg::*;

  lsq_idx_t          sq_tail;
  lsq_idx_t          lq_tail;
  lsq_idx_t          load_bound;
  logic              sq_full;
  logic              lq_full;
  logic              alloc;
  logic              fwd_hit;
  logic [data_w-1:0] fwd_data;

  // Only the queue picked by is_store can refuse
  assign dispatch_ready = dispatch.is_store ? !sq_full : !lq_full;
  assign dispatch_idx   = dispatch.is_store ? sq_tail : lq_tail;
  assign alloc          = dispatch.valid && dispatch_ready;

  store_queue sq0 (
    .clock        (clock),
    .reset        (reset),
    .dispatch     (dispatch),
    .alloc        (alloc),
    .store_exec   (store_exec),
    .retire_store (retire.store),
    .store_ack    (store_ack),
    .load_bound   (load_bound),
    .load_addr    (load_exec.addr),
    .tail         (sq_tail),
    .full         (sq_full),
    .fwd_hit      (fwd_hit),
    .fwd_data     (fwd_data),
    .store_write  (store_write)
  );

  load_queue lq0 (
    .clock       (clock),
    .reset       (reset),
    .dispatch    (dispatch),
    .alloc       (alloc),
    .sq_tail     (sq_tail),
    .load_exec   (load_exec),
    .retire_load (retire.load),
    .fwd_hit     (fwd_hit),
    .fwd_data    (fwd_data),
    .load_rsp    (load_rsp),
    .tail        (lq_tail),
    .full        (lq_full),
    .load_bound  (load_bound),
    .load_accept (load_accept),
    .load_read   (load_read),
    .load_result (load_result)
  );

endmodule

/* logic/load_queue.sv */
`timescale 1ns/1ns

module load_queue (
  input  logic                              clock,
  input  logic                              reset,
  input  lsq_types_pkg::dispatch_req_t      dispatch,
  input  logic                              alloc,
  input  lsq_types_pkg::lsq_idx_t           sq_tail,
  input  lsq_types_pkg::load_exec_t         load_exec,
  input  logic                              retire_load,
  input  logic                              fwd_hit,
  input  logic [lsq_cfg_pkg::data_w-1:0]    fwd_data,
  input  lsq_types_pkg::cache_rsp_t         load_rsp,
  output lsq_types_pkg::lsq_idx_t           tail,
  output logic                              full,
  output lsq_types_pkg::lsq_idx_t           load_bound,
  output logic                              load_accept,
  output lsq_types_pkg::cache_read_t        load_read,
  output lsq_types_pkg::load_result_t       load_result
);

  import lsq_cfg_pkg::*;
  import lsq_types_pkg::*;

  lq_entry_t [lsq_depth-1:0] lq;
  lsq_idx_t                  head;
  lsq_idx_t                  tail_plus_one;
  logic                      load_alloc;

  assign tail_plus_one = tail + 1'b1;
  assign full          = tail_plus_one == head;
  assign load_alloc    = alloc && !dispatch.is_store;
  assign load_bound    = lq[load_exec.lq_idx].sq_bound;

  // Cache only read when no older store matches
  assign load_read.rd_en = load_exec.valid && !fwd_hit;
  assign load_read.addr  = load_exec.addr;
  assign load_accept     = load_exec.valid && (fwd_hit || load_rsp.valid);

  always_ff @(posedge clock) begin
    if (reset) begin
      head <= '0;
      tail <= '0;
    end else begin
      if (load_alloc) begin
        lq[tail].sq_bound <= sq_tail;
        lq[tail].done     <= 1'b0;
        tail              <= tail_plus_one;
      end
      if (load_accept) begin
        lq[load_exec.lq_idx].done <= 1'b1;
      end
      if (retire_load) begin
        head <= head + 1'b1;
      end
    end
  end

  // Result goes out one clock after accept
  always_ff @(posedge clock) begin
    if (reset) begin
      load_result.done <= 1'b0;
    end else begin
      load_result.done <= load_accept;
      if (load_accept) begin
        load_result.lq_idx    <= load_exec.lq_idx;
        load_result.forwarded <= fwd_hit;
        load_result.data      <= fwd_hit ? fwd_data : load_rsp.data;
      end
    end
  end

endmodule

/* logic/store_queue.sv */
`timescale 1ns/1ns

module store_queue (
  input  logic                              clock,
  input  logic                              reset,
  input  lsq_types_pkg::dispatch_req_t      dispatch,
  input  logic                              alloc,
  input  lsq_types_pkg::store_exec_t        store_exec,
  input  logic                              retire_store,
  input  logic                              store_ack,
  input  lsq_types_pkg::lsq_idx_t           load_bound,
  input  logic [lsq_cfg_pkg::addr_w-1:0]    load_addr,
  output lsq_types_pkg::lsq_idx_t           tail,
  output logic                              full,
  output logic                              fwd_hit,
  output logic [lsq_cfg_pkg::data_w-1:0]    fwd_data,
  output lsq_types_pkg::cache_write_t       store_write
);

  import lsq_cfg_pkg::*;
  import lsq_types_pkg::*;

  sq_entry_t [lsq_depth-1:0] sq;
  lsq_idx_t                  head;
  lsq_idx_t                  tail_plus_one;
  lsq_idx_t                  head_plus_one;
  logic                      store_alloc;
  logic                      commit;

  assign tail_plus_one = tail + 1'b1;
  assign head_plus_one = head + 1'b1;
  assign full          = tail_plus_one == head;
  assign store_alloc   = alloc && dispatch.is_store;

  // Head store goes to the cache while retire holds, until acknowledged
  assign store_write.wr_en = retire_store && sq[head].valid;
  assign store_write.addr  = sq[head].addr;
  assign store_write.data  = sq[head].data;
  assign commit            = store_write.wr_en && store_ack;

  always_ff @(posedge clock) begin
    if (reset) begin
      head <= '0;
      tail <= '0;
      for (int i = 0; i < lsq_depth; i++) begin
        sq[i].valid <= 1'b0;
      end
    end else begin
      if (store_alloc) begin
        sq[tail].valid <= 1'b0;
        tail           <= tail_plus_one;
      end
      // Address and data arrive at execute
      if (store_exec.valid) begin
        sq[store_exec.sq_idx].valid <= 1'b1;
        sq[store_exec.sq_idx].addr  <= store_exec.addr;
        sq[store_exec.sq_idx].data  <= store_exec.data;
      end
      if (commit) begin
        head <= head_plus_one;
      end
    end
  end

  store_forward fwd0 (
    .entries (sq),
    .head    (head),
    .bound   (load_bound),
    .addr    (load_addr),
    .hit     (fwd_hit),
    .data    (fwd_data)
  );

endmodule

/* logic/store_forward.sv */
`timescale 1ns/1ns

module store_forward (
  input  lsq_types_pkg::sq_entry_t [lsq_cfg_pkg::lsq_depth-1:0] entries,
  input  lsq_types_pkg::lsq_idx_t                              head,
  input  lsq_types_pkg::lsq_idx_t                              bound,
  input  logic [lsq_cfg_pkg::addr_w-1:0]                       addr,
  output logic                                                 hit,
  output logic [lsq_cfg_pkg::data_w-1:0]                       data
);

  import lsq_cfg_pkg::*;
  import lsq_types_pkg::*;

  // Number of stores older than the load still in the queue
  lsq_idx_t older;

  assign older = bound - head;

  // Walk from youngest older store down to the head, first match wins
  always_comb begin
    lsq_idx_t idx;
    hit  = 1'b0;
    data = '0;
    idx  = bound;
    for (int k = 1; k < lsq_depth; k++) begin
      idx = bound - lsq_idx_t'(k);
      if (!hit && k <= int'(older) && entries[idx].valid && entries[idx].addr == addr) begin
        hit  = 1'b1;
        data = entries[idx].data;
      end
    end
  end

endmodule

/* logic/lsq_types_pkg.sv */
package lsq_types_pkg;

  import lsq_cfg_pkg::*;

  typedef logic [lsq_idx_w-1:0] lsq_idx_t;

  typedef struct packed {
    logic valid;
    logic is_store;
  } dispatch_req_t;

  typedef struct packed {
    logic              valid;
    lsq_idx_t          sq_idx;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] data;
  } store_exec_t;

  typedef struct packed {
    logic              valid;
    lsq_idx_t          lq_idx;
    logic [addr_w-1:0] addr;
  } load_exec_t;

  typedef struct packed {
    logic store;
    logic load;
  } retire_req_t;

  typedef struct packed {
    logic              valid;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] data;
  } sq_entry_t;

  // Store tail seen at dispatch marks the load's age among the stores
  typedef struct packed {
    lsq_idx_t sq_bound;
    logic     done;
  } lq_entry_t;

  typedef struct packed {
    logic              wr_en;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] data;
  } cache_write_t;

  typedef struct packed {
    logic              rd_en;
    logic [addr_w-1:0] addr;
  } cache_read_t;

  typedef struct packed {
    logic              valid;
    logic [data_w-1:0] data;
  } cache_rsp_t;

  typedef struct packed {
    logic              done;
    lsq_idx_t          lq_idx;
    logic              forwarded;
    logic [data_w-1:0] data;
  } load_result_t;

endpackage

/* logic/lsq_cfg_pkg.sv */
package lsq_cfg_pkg;

  // Entries per queue, one slot kept empty to tell full from empty
  localparam int lsq_depth = 8;

  localparam int lsq_idx_w = 3;

  // Doubleword address, bits 63:3 of the effective address
  localparam int addr_w = 61;

  localparam int data_w = 64;

endpackage
